// File: rtl/exec_core_defs.svh
// Width and count macros shared by the execute and writeback core

`ifndef EXEC_CORE_DEFS_SVH
`define EXEC_CORE_DEFS_SVH

////////////////////////////////////////////////////////////
// Datapath widths

// Operand and result width
`define EXEC_XLEN 32

// Instruction ID width, 16 IDs in flight at most
`define EXEC_ID_W 4

////////////////////////////////////////////////////////////
// Unit configuration

// Units that return results through writeback
`define EXEC_NUM_UNITS 3

// Shift-subtract steps per divide
`define EXEC_DIV_CYCLES 32

`endif

// File: rtl/exec_core_pkg.sv
// Operation encodings, unit indices and packet types for the execute core

`include "exec_core_defs.svh"

package exec_core_pkg;

    ////////////////////////////////////////////////////////////
    // Operations
    typedef enum logic [3:0] {
        OP_ADD   = 4'd0,
        OP_SUB   = 4'd1,
        OP_AND   = 4'd2,
        OP_OR    = 4'd3,
        OP_XOR   = 4'd4,
        OP_SLL   = 4'd5,
        OP_SRL   = 4'd6,
        OP_MUL   = 4'd7,
        OP_MULHU = 4'd8,
        OP_DIVU  = 4'd9,
        OP_REMU  = 4'd10
    } op_t;

    // Unit index, lowest value wins first after reset
    typedef enum logic [1:0] {
        UNIT_ALU = 2'd0,
        UNIT_MUL = 2'd1,
        UNIT_DIV = 2'd2
    } unit_t;

    ////////////////////////////////////////////////////////////
    // Packets

    // Decoded operation as it leaves issue
    typedef struct packed {
        logic [`EXEC_ID_W-1:0] id;
        op_t op;
        logic [`EXEC_XLEN-1:0] rs1;
        logic [`EXEC_XLEN-1:0] rs2;
    } issue_packet_t;

    // Finished result tagged with its instruction ID
    typedef struct packed {
        logic [`EXEC_ID_W-1:0] id;
        logic [`EXEC_XLEN-1:0] data;
    } wb_packet_t;

endpackage

// File: rtl/issue_dispatch.sv
// Issue dispatcher that steers each operation to its execution unit

`timescale 1ns/1ps

`include "exec_core_defs.svh"

module issue_dispatch (
        input logic issue_valid,
        input exec_core_pkg::op_t op,

        input logic [`EXEC_NUM_UNITS-1:0] unit_ready,
        output logic [`EXEC_NUM_UNITS-1:0] unit_request,

        output logic issue_ready
    );

    exec_core_pkg::unit_t unit_sel;

    ////////////////////////////////////////////////////////////
    // Unit decode
    // Only place where an operation is mapped to a unit
    always_comb begin
        case (op)
            exec_core_pkg::OP_MUL,
            exec_core_pkg::OP_MULHU: unit_sel = exec_core_pkg::UNIT_MUL;
            exec_core_pkg::OP_DIVU,
            exec_core_pkg::OP_REMU: unit_sel = exec_core_pkg::UNIT_DIV;
            default: unit_sel = exec_core_pkg::UNIT_ALU;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Request and ready routing

    // One-hot request toward the selected unit
    always_comb begin
        unit_request = '0;
        unit_request[unit_sel] = issue_valid;
    end

    // Issue stalls only on the unit this op needs
    assign issue_ready = unit_ready[unit_sel];

endmodule

// File: rtl/alu_unit.sv
// Single-cycle ALU with a held result register toward writeback

`timescale 1ns/1ps

`include "exec_core_defs.svh"

module alu_unit (
        input logic clk,
        input logic rst,

        input logic request,
        input exec_core_pkg::issue_packet_t issue,
        output logic ready,

        output logic done,
        output exec_core_pkg::wb_packet_t result,
        input logic ack
    );

    localparam int SHAMT_W = $clog2(`EXEC_XLEN);

    logic [SHAMT_W-1:0] shamt;
    logic [`EXEC_XLEN-1:0] alu_result;
    logic accept;

    ////////////////////////////////////////////////////////////
    // Datapath
    assign shamt = issue.rs2[SHAMT_W-1:0];

    always_comb begin
        case (issue.op)
            exec_core_pkg::OP_SUB: alu_result = issue.rs1 - issue.rs2;
            exec_core_pkg::OP_AND: alu_result = issue.rs1 & issue.rs2;
            exec_core_pkg::OP_OR:  alu_result = issue.rs1 | issue.rs2;
            exec_core_pkg::OP_XOR: alu_result = issue.rs1 ^ issue.rs2;
            exec_core_pkg::OP_SLL: alu_result = issue.rs1 << shamt;
            exec_core_pkg::OP_SRL: alu_result = issue.rs1 >> shamt;
            default: alu_result = issue.rs1 + issue.rs2;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Output register
    // Free when empty or being drained this cycle
    assign ready = ~done | ack;
    assign accept = request & ready;

    always_ff @(posedge clk) begin
        if (rst)
            done <= 1'b0;
        else if (accept)
            done <= 1'b1;
        else if (ack)
            done <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            result.id <= issue.id;
            result.data <= alu_result;
        end
    end

endmodule

// File: rtl/mul_unit.sv
// Two-stage pipelined unsigned multiplier returning the low or high word

`timescale 1ns/1ps

`include "exec_core_defs.svh"

module mul_unit (
        input logic clk,
        input logic rst,

        input logic request,
        input exec_core_pkg::issue_packet_t issue,
        output logic ready,

        output logic done,
        output exec_core_pkg::wb_packet_t result,
        input logic ack
    );

    // Stage one
    logic s1_valid;
    exec_core_pkg::issue_packet_t s1_packet;

    // Stage two, its valid is done
    logic [`EXEC_ID_W-1:0] s2_id;
    logic [2*`EXEC_XLEN-1:0] s2_product;
    logic s2_high;

    logic s1_free;
    logic s2_free;

    ////////////////////////////////////////////////////////////
    // Pipeline control
    // A stage moves only when the next one is empty or being acked
    assign s2_free = ~done | ack;
    assign s1_free = ~s1_valid | s2_free;
    assign ready = s1_free;

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
            done <= 1'b0;
        end else begin
            if (s1_free)
                s1_valid <= request;
            if (s2_free)
                done <= s1_valid;
        end
    end

    ////////////////////////////////////////////////////////////
    // Stage one, capture operands
    always_ff @(posedge clk) begin
        if (request & s1_free)
            s1_packet <= issue;
    end

    ////////////////////////////////////////////////////////////
    // Stage two, full product
    always_ff @(posedge clk) begin
        if (s1_valid & s2_free) begin
            s2_id <= s1_packet.id;
            s2_product <= (2*`EXEC_XLEN)'(s1_packet.rs1) * (2*`EXEC_XLEN)'(s1_packet.rs2);
            s2_high <= (s1_packet.op == exec_core_pkg::OP_MULHU);
        end
    end

    // Word select for MUL or MULHU
    assign result.id = s2_id;
    assign result.data = s2_high ? s2_product[2*`EXEC_XLEN-1:`EXEC_XLEN]
                                 : s2_product[`EXEC_XLEN-1:0];

endmodule

// File: rtl/div_unit.sv
// Iterative restoring divider for unsigned quotient and remainder

`timescale 1ns/1ps

`include "exec_core_defs.svh"

module div_unit (
        input logic clk,
        input logic rst,

        input logic request,
        input exec_core_pkg::issue_packet_t issue,
        output logic ready,

        output logic done,
        output exec_core_pkg::wb_packet_t result,
        input logic ack
    );

    localparam int CNT_W = $clog2(`EXEC_DIV_CYCLES);

    logic busy;
    logic last;
    logic accept;
    logic [CNT_W-1:0] count;

    // Quotient shifts in from the dividend side
    logic [`EXEC_XLEN-1:0] quotient;
    logic [`EXEC_XLEN-1:0] remainder;
    logic [`EXEC_XLEN-1:0] divisor;
    logic [`EXEC_ID_W-1:0] div_id;
    logic rem_sel;

    logic [`EXEC_XLEN:0] shifted;
    logic [`EXEC_XLEN-1:0] diff;
    logic no_borrow;

    ////////////////////////////////////////////////////////////
    // One shift-subtract step
    assign shifted = {remainder, quotient[`EXEC_XLEN-1]};
    assign diff = shifted[`EXEC_XLEN-1:0] - divisor;
    assign no_borrow = (shifted >= {1'b0, divisor});

    ////////////////////////////////////////////////////////////
    // Control
    // Busy from acceptance through the final step
    assign last = (count == CNT_W'(`EXEC_DIV_CYCLES - 1));
    assign ready = ~busy & (~done | ack);
    assign accept = request & ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            done <= 1'b0;
            count <= '0;
        end else begin
            if (accept) begin
                busy <= 1'b1;
                count <= '0;
            end else if (busy) begin
                busy <= ~last;
                count <= count + 1'b1;
            end
            if (busy & last)
                done <= 1'b1;
            else if (ack)
                done <= 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////
    // Working registers, also the held result
    always_ff @(posedge clk) begin
        if (accept) begin
            quotient <= issue.rs1;
            remainder <= '0;
            divisor <= issue.rs2;
            div_id <= issue.id;
            rem_sel <= (issue.op == exec_core_pkg::OP_REMU);
        end else if (busy) begin
            quotient <= {quotient[`EXEC_XLEN-2:0], no_borrow};
            remainder <= no_borrow ? diff : shifted[`EXEC_XLEN-1:0];
        end
    end

    // Zero divisor falls out as all ones and the dividend
    assign result.id = div_id;
    assign result.data = rem_sel ? remainder : quotient;

endmodule

// File: rtl/writeback_arbiter.sv
// Round-robin writeback arbiter merging unit results onto one port

`timescale 1ns/1ps

`include "exec_core_defs.svh"

module writeback_arbiter (
        input logic clk,
        input logic rst,

        input logic [`EXEC_NUM_UNITS-1:0] done,
        input exec_core_pkg::wb_packet_t [`EXEC_NUM_UNITS-1:0] result,
        output logic [`EXEC_NUM_UNITS-1:0] ack,

        output logic wb_valid,
        output exec_core_pkg::wb_packet_t wb
    );

    localparam int IDX_W = $clog2(`EXEC_NUM_UNITS);

    logic [IDX_W-1:0] last_grant;
    logic [IDX_W-1:0] grant_idx;
    logic found;

    ////////////////////////////////////////////////////////////
    // Selection
    // Search starts at the unit after the last grant
    always_comb begin
        logic [IDX_W:0] idx;
        found = 1'b0;
        grant_idx = last_grant;
        for (int i = 1; i <= `EXEC_NUM_UNITS; i++) begin
            idx = {1'b0, last_grant} + (IDX_W + 1)'(i);
            if (idx >= (IDX_W + 1)'(`EXEC_NUM_UNITS))
                idx = idx - (IDX_W + 1)'(`EXEC_NUM_UNITS);
            if (!found && done[idx[IDX_W-1:0]]) begin
                found = 1'b1;
                grant_idx = idx[IDX_W-1:0];
            end
        end
        ack = '0;
        ack[grant_idx] = found;
    end

    ////////////////////////////////////////////////////////////
    // Writeback register
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_valid <= 1'b0;
            last_grant <= IDX_W'(`EXEC_NUM_UNITS - 1);
        end else begin
            wb_valid <= found;
            if (found)
                last_grant <= grant_idx;
        end
    end

    always_ff @(posedge clk) begin
        if (found)
            wb <= result[grant_idx];
    end

endmodule

// File: rtl/exec_core.sv
// Execute and writeback top with dispatch, three units and the arbiter

`timescale 1ns/1ps

`include "exec_core_defs.svh"

module exec_core (
        input logic clk,
        input logic rst,

        input logic issue_valid,
        input exec_core_pkg::issue_packet_t issue,
        output logic issue_ready,

        output logic wb_valid,
        output exec_core_pkg::wb_packet_t wb
    );

    ////////////////////////////////////////////////////////////
    // Connecting signals
    logic [`EXEC_NUM_UNITS-1:0] unit_request;
    logic [`EXEC_NUM_UNITS-1:0] unit_ready;
    logic [`EXEC_NUM_UNITS-1:0] unit_done;
    logic [`EXEC_NUM_UNITS-1:0] unit_ack;
    exec_core_pkg::wb_packet_t [`EXEC_NUM_UNITS-1:0] unit_result;

    ////////////////////////////////////////////////////////////
    // Dispatch
    issue_dispatch dispatch_block (
        .issue_valid (issue_valid),
        .op (issue.op),
        .unit_ready (unit_ready),
        .unit_request (unit_request),
        .issue_ready (issue_ready)
    );

    ////////////////////////////////////////////////////////////
    // Execution units
    alu_unit alu_unit_block (
        .clk (clk),
        .rst (rst),
        .request (unit_request[exec_core_pkg::UNIT_ALU]),
        .issue (issue),
        .ready (unit_ready[exec_core_pkg::UNIT_ALU]),
        .done (unit_done[exec_core_pkg::UNIT_ALU]),
        .result (unit_result[exec_core_pkg::UNIT_ALU]),
        .ack (unit_ack[exec_core_pkg::UNIT_ALU])
    );

    mul_unit mul_unit_block (
        .clk (clk),
        .rst (rst),
        .request (unit_request[exec_core_pkg::UNIT_MUL]),
        .issue (issue),
        .ready (unit_ready[exec_core_pkg::UNIT_MUL]),
        .done (unit_done[exec_core_pkg::UNIT_MUL]),
        .result (unit_result[exec_core_pkg::UNIT_MUL]),
        .ack (unit_ack[exec_core_pkg::UNIT_MUL])
    );

    div_unit div_unit_block (
        .clk (clk),
        .rst (rst),
        .request (unit_request[exec_core_pkg::UNIT_DIV]),
        .issue (issue),
        .ready (unit_ready[exec_core_pkg::UNIT_DIV]),
        .done (unit_done[exec_core_pkg::UNIT_DIV]),
        .result (unit_result[exec_core_pkg::UNIT_DIV]),
        .ack (unit_ack[exec_core_pkg::UNIT_DIV])
    );

    ////////////////////////////////////////////////////////////
    // Writeback
    writeback_arbiter writeback_block (
        .clk (clk),
        .rst (rst),
        .done (unit_done),
        .result (unit_result),
        .ack (unit_ack),
        .wb_valid (wb_valid),
        .wb (wb)
    );

endmodule

// File: bench/exec_core_model.svh
// Reference model for the execute core testbench with random source and per-ID result table

`ifndef EXEC_CORE_MODEL_SVH
`define EXEC_CORE_MODEL_SVH

////////////////////////////////////////////////////////////
// Random source
logic [31:0] lcg_state = 32'h71a83f74;

function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
endfunction

////////////////////////////////////////////////////////////
// Per-ID bookkeeping
// An ID is outstanding while its issue and return counts differ
logic [`EXEC_XLEN-1:0] expected_data [1 << `EXEC_ID_W];
int issue_seq [1 << `EXEC_ID_W];
int return_seq [1 << `EXEC_ID_W];
int accept_cycle [1 << `EXEC_ID_W];
logic [`EXEC_ID_W-1:0] id_ptr = '0;

// Search starts after the last ID handed out
function automatic logic find_free_id(output logic [`EXEC_ID_W-1:0] id);
    logic [`EXEC_ID_W-1:0] cand;
    logic found;
    found = 1'b0;
    id = id_ptr;
    for (int i = 0; i < (1 << `EXEC_ID_W); i++) begin
        cand = id_ptr + i[`EXEC_ID_W-1:0];
        if (!found && issue_seq[cand] == return_seq[cand]) begin
            found = 1'b1;
            id = cand;
        end
    end
    return found;
endfunction

////////////////////////////////////////////////////////////
// Expected data from the operation rules
function automatic logic [`EXEC_XLEN-1:0] model_result(
        input exec_core_pkg::op_t op,
        input logic [`EXEC_XLEN-1:0] a,
        input logic [`EXEC_XLEN-1:0] b
    );
    logic [2*`EXEC_XLEN-1:0] product;
    product = {{`EXEC_XLEN{1'b0}}, a} * {{`EXEC_XLEN{1'b0}}, b};
    case (op)
        exec_core_pkg::OP_ADD: return a + b;
        exec_core_pkg::OP_SUB: return a - b;
        exec_core_pkg::OP_AND: return a & b;
        exec_core_pkg::OP_OR: return a | b;
        exec_core_pkg::OP_XOR: return a ^ b;
        // Shift amount is the low five bits of rs2
        exec_core_pkg::OP_SLL: return a << b[4:0];
        exec_core_pkg::OP_SRL: return a >> b[4:0];
        exec_core_pkg::OP_MUL: return product[`EXEC_XLEN-1:0];
        exec_core_pkg::OP_MULHU: return product[2*`EXEC_XLEN-1:`EXEC_XLEN];
        // Zero divisor gives all ones and the dividend
        exec_core_pkg::OP_DIVU: return (b == '0) ? {`EXEC_XLEN{1'b1}} : a / b;
        exec_core_pkg::OP_REMU: return (b == '0) ? a : a % b;
        default: return '0;
    endcase
endfunction

`endif

// File: bench/exec_core_tb.sv
// Testbench for the execute core driving random operations against a reference model

`timescale 1ns/1ps

`include "exec_core_defs.svh"

module exec_core_tb;

    localparam int TIMEOUT_CYCLES = 400 * (`EXEC_DIV_CYCLES + 8) + 200;

    logic clk;
    logic rst;
    logic issue_valid;
    exec_core_pkg::issue_packet_t issue;
    logic issue_ready;
    logic wb_valid;
    exec_core_pkg::wb_packet_t wb;

    int cycle_count = 0;
    int issued_count = 0;
    int returned_count = 0;
    int check_errors = 0;
    int monitor_errors = 0;
    int last_latency = 0;
    int tests_failed = 0;
    int peak_in_flight = 0;

    `include "exec_core_model.svh"

    exec_core UUT (
        .clk (clk),
        .rst (rst),
        .issue_valid (issue_valid),
        .issue (issue),
        .issue_ready (issue_ready),
        .wb_valid (wb_valid),
        .wb (wb)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Cycle count and run limit
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles with %0d IDs still outstanding",
                     cycle_count, issued_count - returned_count);
            $display("Simulation FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // Writeback monitor, sampled on the falling edge
    always @(negedge clk) begin
        if (!rst && wb_valid) begin
            if (issue_seq[wb.id] == return_seq[wb.id]) begin
                $display("Writeback carried ID %0h which is not outstanding", wb.id);
                monitor_errors++;
            end else begin
                if (wb.data !== expected_data[wb.id]) begin
                    $display("MISMATCH wb.data ID %0h: got %08h expected %08h",
                             wb.id, wb.data, expected_data[wb.id]);
                    monitor_errors++;
                end
                last_latency = cycle_count - accept_cycle[wb.id];
                return_seq[wb.id] = return_seq[wb.id] + 1;
                returned_count++;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Stimulus helpers, all entered 1 ns after a rising edge
    task automatic issue_op(input exec_core_pkg::op_t op,
                            input logic [`EXEC_XLEN-1:0] a,
                            input logic [`EXEC_XLEN-1:0] b);
        logic [`EXEC_ID_W-1:0] id;
        logic accepted;
        while (!find_free_id(id)) begin
            @(posedge clk);
            #1;
        end
        issue_seq[id] = issue_seq[id] + 1;
        expected_data[id] = model_result(op, a, b);
        issue_valid = 1'b1;
        issue.id = id;
        issue.op = op;
        issue.rs1 = a;
        issue.rs2 = b;
        accepted = 1'b0;
        while (!accepted) begin
            @(negedge clk);
            accepted = issue_ready;
        end
        // Transfer happens on the coming rising edge
        accept_cycle[id] = cycle_count;
        issued_count++;
        @(posedge clk);
        #1;
        issue_valid = 1'b0;
        id_ptr = id + `EXEC_ID_W'(1);
        if (issued_count - returned_count > peak_in_flight)
            peak_in_flight = issued_count - returned_count;
    endtask

    task automatic issue_random(input exec_core_pkg::op_t op, input logic zero_b);
        logic [`EXEC_XLEN-1:0] a;
        logic [`EXEC_XLEN-1:0] b;
        a = next_rand();
        b = next_rand();
        // Narrower divisors give nontrivial quotients
        if (op == exec_core_pkg::OP_DIVU || op == exec_core_pkg::OP_REMU)
            b = b >> a[4:0];
        if (zero_b)
            b = '0;
        issue_op(op, a, b);
    endtask

    function automatic exec_core_pkg::op_t pick_op(input logic [31:0] base,
                                                   input logic [31:0] span);
        return exec_core_pkg::op_t'(4'(base + next_rand() % span));
    endfunction

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic wait_drained();
        while (returned_count != issued_count) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic check_latency(input int expected);
        if (last_latency != expected) begin
            $display("MISMATCH wb_valid latency: got %0h expected %0h", last_latency, expected);
            check_errors++;
        end
    endtask

    task automatic report_test(input int num, input string name, input int errs_before);
        int errs;
        wait_drained();
        errs = check_errors + monitor_errors - errs_before;
        if (errs == 0) begin
            $display("Test %0d %s: ok", num, name);
        end else begin
            $display("Test %0d %s: failed with %0d errors", num, name, errs);
            tests_failed++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Test sequence
    initial begin
        int errs_before;
        rst = 1'b1;
        issue_valid = 1'b0;
        issue = '0;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;

        // Every unit idle and ready
        errs_before = check_errors + monitor_errors;
        for (int k = 0; k < 11; k++) begin
            issue.op = exec_core_pkg::op_t'(4'(k));
            @(negedge clk);
            if (issue_ready !== 1'b1) begin
                $display("MISMATCH issue_ready op %0h: got %0h expected 1", k, issue_ready);
                check_errors++;
            end
            if (wb_valid !== 1'b0) begin
                $display("MISMATCH wb_valid op %0h: got %0h expected 0", k, wb_valid);
                check_errors++;
            end
            @(posedge clk);
            #1;
        end
        report_test(1, "idle after reset", errs_before);

        // One ALU op, then one divide, each alone in the core
        errs_before = check_errors + monitor_errors;
        issue_random(pick_op(32'd0, 32'd7), 1'b0);
        wait_drained();
        check_latency(2);
        issue_random(pick_op(32'd9, 32'd2), 1'b0);
        wait_drained();
        check_latency(`EXEC_DIV_CYCLES + 2);
        report_test(2, "isolated latency", errs_before);

        errs_before = check_errors + monitor_errors;
        for (int k = 0; k < 100; k++)
            issue_random(pick_op(32'd0, 32'd7), 1'b0);
        report_test(3, "ALU back to back", errs_before);

        errs_before = check_errors + monitor_errors;
        peak_in_flight = 0;
        for (int k = 0; k < 100; k++)
            issue_random(pick_op(32'd7, 32'd2), 1'b0);
        if (peak_in_flight < 2) begin
            $display("Multiplier never held more than one operation in flight");
            check_errors++;
        end
        report_test(4, "multiplier back to back", errs_before);

        errs_before = check_errors + monitor_errors;
        for (int k = 0; k < 50; k++)
            issue_random(pick_op(32'd9, 32'd2), (k % 6) == 0);
        report_test(5, "divider with zero divisors", errs_before);

        errs_before = check_errors + monitor_errors;
        for (int k = 0; k < 150; k++) begin
            issue_random(pick_op(32'd0, 32'd11), (k % 13) == 0);
            idle_cycles(int'(next_rand() % 32'd4));
        end
        report_test(6, "mixed with gaps", errs_before);

        $display("Tests run 6, failed %0d, errors %0d, results checked %0d",
                 tests_failed, check_errors + monitor_errors, returned_count);
        if (check_errors + monitor_errors == 0 && tests_failed == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: exec_core.f
+incdir+rtl
+incdir+bench
rtl/exec_core_pkg.sv
rtl/issue_dispatch.sv
rtl/alu_unit.sv
rtl/mul_unit.sv
rtl/div_unit.sv
rtl/writeback_arbiter.sv
rtl/exec_core.sv
bench/exec_core_tb.sv

// File: Makefile
TOOL     := verilator
TOP      := exec_core_tb
FILELIST := exec_core.f
FLAGS    := --binary --timing --timescale 1ns/1ps -j 0
BUILD    := obj_dir
LOG      := sim.log

.PHONY: sim clean

# Build, run, then decide the verdict from the log
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
